// ==== verilog.f ====
shim_pkg.sv
addr_demux.sv
soc_id_queue.sv
reorder_buffer.sv
tcdm_shim.sv
tcdm_shim_sva.sv
tb_tcdm_shim.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the TCDM shim testbench
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_tcdm_shim \
  -o tb_tcdm_shim || exit 1
./obj_dir/tb_tcdm_shim +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

// ==== tb_tcdm_shim.sv ====
/*
 * Testbench for the TCDM shim with random core traffic against TCDM and SoC
 * responder models, checked by the bound assertions
 */
module tb_tcdm_shim;

  localparam int N_REQ      = 3000;
  localparam int MAX_CYCLES = N_REQ * 20;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic [31:0] data_qaddr_i, data_qdata_i, data_pdata_o;
  logic [3:0]  data_qstrb_i, tcdm_req_be_o, soc_qstrb_o;
  logic        data_qwrite_i, data_qvalid_i, data_qready_o, data_pready_i;
  logic        data_pvalid_o, data_perror_o, tcdm_req_valid_o, tcdm_req_ready_i;
  logic [1:0]  tcdm_req_bank_o;
  logic [15:0] tcdm_req_row_o;
  logic        tcdm_req_wen_o, tcdm_resp_valid_i, soc_qvalid_o, soc_qready_i;
  logic [31:0] tcdm_req_wdata_o, tcdm_resp_rdata_i, soc_qaddr_o, soc_qdata_o, soc_pdata_i;
  logic [2:0]  tcdm_req_id_o, tcdm_resp_id_i;
  logic        soc_qwrite_o, soc_pvalid_i, soc_pready_o, soc_perror_i;

  logic [31:0] rng = 32'hcbee_0432;
  logic [31:0] mem [256];
  logic [31:0] pend_data [8];
  int          pend_dly [8];
  logic [7:0]  pend_valid;
  logic [31:0] soc_q [$];
  logic [31:0] a;
  // Handshakes and fields seen at the rising edge
  logic        s_qfire, s_read, s_tfire, s_wen, s_sread, s_pfire;
  logic [7:0]  s_idx;
  logic [31:0] s_wdata, s_saddr;
  logic [3:0]  s_be;
  logic [2:0]  s_id;
  int          issued = 0;
  int          outstanding = 0;
  int          cycles = 0;
  int          timeouts = 0;
  int          errors;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3c, ~a, a, a ^ 8'ha5};
  endfunction

  tcdm_shim dut0 (.*);

  always #4 clk_i = ~clk_i;

  initial begin
    rst_n_i = 1'b0;
    {data_qaddr_i, data_qdata_i, data_qstrb_i, data_qwrite_i, data_qvalid_i} = '0;
    {data_pready_i, tcdm_req_ready_i, soc_qready_i, soc_pvalid_i, soc_perror_i} = '0;
    {tcdm_resp_valid_i, tcdm_resp_rdata_i, tcdm_resp_id_i, soc_pdata_i} = '0;
    pend_valid = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(8'(i));
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);
    while ((issued < N_REQ || outstanding != 0) && cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      s_qfire = data_qvalid_i & data_qready_o;
      s_read  = s_qfire & ~data_qwrite_i;
      s_tfire = tcdm_req_valid_o & tcdm_req_ready_i;
      s_wen   = tcdm_req_wen_o;
      s_idx   = {tcdm_req_row_o[5:0], tcdm_req_bank_o};
      s_wdata = tcdm_req_wdata_o;
      s_be    = tcdm_req_be_o;
      s_id    = tcdm_req_id_o;
      s_sread = soc_qvalid_o & soc_qready_i & ~soc_qwrite_o;
      s_saddr = soc_qaddr_o;
      s_pfire = data_pvalid_o & data_pready_i;
      @(negedge clk_i);
      cycles++;
      if (s_qfire) issued++;
      if (s_read) outstanding++;
      if (s_pfire) outstanding--;
      rng = xorshift32(rng);
      // TCDM bank model samples read data at acceptance
      if (s_tfire && s_wen) begin
        for (int b = 0; b < 4; b++) begin
          if (s_be[b]) mem[s_idx][8*b +: 8] = s_wdata[8*b +: 8];
        end
      end else if (s_tfire) begin
        pend_valid[s_id] = 1'b1;
        pend_data[s_id]  = mem[s_idx];
        pend_dly[s_id]   = int'(rng % 32'd6);
      end
      tcdm_resp_valid_i = 1'b0;
      for (int i = 0; i < 8; i++) begin
        if (pend_valid[i] && pend_dly[i] > 0) begin
          pend_dly[i]--;
        end else if (pend_valid[i] && !tcdm_resp_valid_i) begin
          tcdm_resp_valid_i = 1'b1;
          tcdm_resp_id_i    = 3'(i);
          tcdm_resp_rdata_i = pend_data[i];
          pend_valid[i]     = 1'b0;
        end
      end
      // SoC model answers in order
      if (s_sread) soc_q.push_back(s_saddr);
      soc_pvalid_i = 1'b0;
      if (soc_q.size() > 0 && rng[11:10] != 2'd0) begin
        a            = soc_q.pop_front();
        soc_pvalid_i = 1'b1;
        soc_pdata_i  = ~a;
        soc_perror_i = (a & shim_pkg::SOC_ERR_MASK) == shim_pkg::SOC_ERR_BASE;
      end
      data_pready_i    = rng[2:0] > 3'd2;
      tcdm_req_ready_i = rng[5:3] != 3'd0;
      soc_qready_i     = rng[8:6] != 3'd0;
      if (s_qfire) data_qvalid_i = 1'b0;
      if (!data_qvalid_i && issued < N_REQ) begin
        rng           = xorshift32(rng);
        data_qvalid_i = rng[1:0] != 2'd0;
        data_qwrite_i = rng[3:2] == 2'd0;
        data_qstrb_i  = rng[31:28];
        case (rng[5:4])
          2'd2:    data_qaddr_i = 32'h8000_0000 | {12'd0, rng[25:8], 2'b00};
          2'd3:    data_qaddr_i = shim_pkg::SOC_ERR_BASE | {12'd0, rng[25:8], 2'b00};
          default: data_qaddr_i = shim_pkg::TCDM_BASE | {22'd0, rng[15:8], 2'b00};
        endcase
        rng          = xorshift32(rng);
        data_qdata_i = rng;
      end
    end
    if (cycles >= MAX_CYCLES) begin
      timeouts = 1;
      $display("timeout: %0d reads still outstanding after %0d cycles", outstanding, cycles);
    end
    errors = dut0.i_tcdm_shim_sva.fail_cnt;
    $display("errors: %0d assertion failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tcdm_shim_sva.sv ====
/*
 * Bound checker for the TCDM shim covering routing, in-order read data against
 * a shadow memory, the error flag, back-pressure and reset values
 */
module tcdm_shim_sva (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic [shim_pkg::ADDR_WIDTH-1:0] data_qaddr_i,
  input logic                            data_qwrite_i,
  input logic [shim_pkg::DATA_WIDTH-1:0] data_qdata_i,
  input logic [shim_pkg::STRB_WIDTH-1:0] data_qstrb_i,
  input logic                            data_qvalid_i,
  input logic                            data_qready_o,
  input logic                            data_pvalid_o,
  input logic                            data_pready_i,
  input logic [shim_pkg::DATA_WIDTH-1:0] data_pdata_o,
  input logic                            data_perror_o,
  input logic                            tcdm_req_valid_o,
  input logic [shim_pkg::BANK_WIDTH-1:0] tcdm_req_bank_o,
  input logic [shim_pkg::ROW_WIDTH-1:0]  tcdm_req_row_o,
  input logic                            tcdm_req_wen_o,
  input logic [shim_pkg::DATA_WIDTH-1:0] tcdm_req_wdata_o,
  input logic [shim_pkg::STRB_WIDTH-1:0] tcdm_req_be_o,
  input logic                            soc_qvalid_o,
  input logic [shim_pkg::ADDR_WIDTH-1:0] soc_qaddr_o,
  input logic                            soc_qwrite_o,
  input logic [shim_pkg::DATA_WIDTH-1:0] soc_qdata_o,
  input logic [shim_pkg::STRB_WIDTH-1:0] soc_qstrb_o,
  input logic                            soc_pvalid_i,
  input logic                            soc_pready_o
);

  logic [31:0] shadow [256];
  logic [31:0] exp_data [8];
  logic [7:0]  exp_err;
  logic [2:0]  exp_wr;
  logic [2:0]  exp_rd;
  logic [3:0]  exp_cnt;
  logic [31:0] exp_head;
  logic        exp_head_err;
  logic        q_fire;
  logic        p_fire;
  logic        in_tcdm;
  logic        in_err;
  int          fail_cnt = 0;

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3c, ~a, a, a ^ 8'ha5};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(8'(i));
    end
  end

  assign q_fire       = data_qvalid_i & data_qready_o;
  assign p_fire       = data_pvalid_o & data_pready_i;
  assign in_tcdm      = (data_qaddr_i & shim_pkg::TCDM_MASK) == shim_pkg::TCDM_BASE;
  assign in_err       = (data_qaddr_i & shim_pkg::SOC_ERR_MASK) == shim_pkg::SOC_ERR_BASE;
  assign exp_head     = exp_data[exp_rd];
  assign exp_head_err = exp_err[exp_rd];

  // Expected responses are fixed when the core read is accepted
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_wr  <= '0;
      exp_rd  <= '0;
      exp_cnt <= '0;
    end else begin
      if (q_fire && !data_qwrite_i) begin
        exp_data[exp_wr] <= in_tcdm ? shadow[data_qaddr_i[9:2]] : ~data_qaddr_i;
        exp_err[exp_wr]  <= !in_tcdm && in_err;
        exp_wr           <= exp_wr + 1'b1;
      end
      if (q_fire && data_qwrite_i && in_tcdm) begin
        shadow[data_qaddr_i[9:2]] <=
          merge_bytes(shadow[data_qaddr_i[9:2]], data_qdata_i, data_qstrb_i);
      end
      if (p_fire) begin
        exp_rd <= exp_rd + 1'b1;
      end
      exp_cnt <= exp_cnt + 4'(q_fire && !data_qwrite_i) - 4'(p_fire);
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
      (!rst_n_i || $rose(rst_n_i)) |-> !data_pvalid_o && !tcdm_req_valid_o && !soc_qvalid_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid output high during or right after reset");
    end

  a_tcdm_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (q_fire && in_tcdm) |-> tcdm_req_valid_o && !soc_qvalid_o
        && {tcdm_req_row_o, tcdm_req_bank_o} == data_qaddr_i[19:2]
        && tcdm_req_wen_o == data_qwrite_i && tcdm_req_wdata_o == data_qdata_i
        && tcdm_req_be_o == data_qstrb_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("MISMATCH tcdm_req_valid_o %h row %h bank %h wdata %h be %h for addr %h",
             $sampled(tcdm_req_valid_o), $sampled(tcdm_req_row_o), $sampled(tcdm_req_bank_o),
             $sampled(tcdm_req_wdata_o), $sampled(tcdm_req_be_o), $sampled(data_qaddr_i));
    end

  a_soc_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (q_fire && !in_tcdm) |-> soc_qvalid_o && !tcdm_req_valid_o
        && soc_qaddr_o == data_qaddr_i && soc_qwrite_o == data_qwrite_i
        && soc_qdata_o == data_qdata_i && soc_qstrb_o == data_qstrb_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("MISMATCH soc_qvalid_o %h soc_qaddr_o %h soc_qdata_o %h soc_qstrb_o %h for addr %h",
             $sampled(soc_qvalid_o), $sampled(soc_qaddr_o), $sampled(soc_qdata_o),
             $sampled(soc_qstrb_o), $sampled(data_qaddr_i));
    end

  a_soc_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      soc_pvalid_i |-> soc_pready_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("SoC response offered while soc_pready_o was low");
    end

  a_response: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      p_fire |-> exp_cnt != 4'd0 && data_pdata_o == exp_head && data_perror_o == exp_head_err)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("MISMATCH data_pdata_o %h exp %h data_perror_o %h exp %h",
             $sampled(data_pdata_o), $sampled(exp_head), $sampled(data_perror_o),
             $sampled(exp_head_err));
    end

  a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (exp_cnt == 4'd8 && data_qvalid_i && !data_qwrite_i) |-> !data_qready_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("read accepted while eight reads were unreturned");
    end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (data_pvalid_o && !data_pready_i) |=> data_pvalid_o && $stable(data_pdata_o)
        && $stable(data_perror_o))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("response dropped or changed while data_pready_i was low");
    end

endmodule

bind tcdm_shim tcdm_shim_sva i_tcdm_shim_sva (.*);

// ==== tcdm_shim.sv ====
/*
 * TCDM shim top level that splits one core load/store port over a TCDM bank
 * port and a SoC bus port, and returns read responses in issue order
 */
module tcdm_shim (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Core request
  input  logic [shim_pkg::ADDR_WIDTH-1:0]   data_qaddr_i,
  input  logic                              data_qwrite_i,
  input  logic [shim_pkg::DATA_WIDTH-1:0]   data_qdata_i,
  input  logic [shim_pkg::STRB_WIDTH-1:0]   data_qstrb_i,
  input  logic                              data_qvalid_i,
  output logic                              data_qready_o,
  // Core response
  output logic                              data_pvalid_o,
  input  logic                              data_pready_i,
  output logic [shim_pkg::DATA_WIDTH-1:0]   data_pdata_o,
  output logic                              data_perror_o,
  // TCDM port
  output logic                              tcdm_req_valid_o,
  input  logic                              tcdm_req_ready_i,
  output logic [shim_pkg::BANK_WIDTH-1:0]   tcdm_req_bank_o,
  output logic [shim_pkg::ROW_WIDTH-1:0]    tcdm_req_row_o,
  output logic                              tcdm_req_wen_o,
  output logic [shim_pkg::DATA_WIDTH-1:0]   tcdm_req_wdata_o,
  output logic [shim_pkg::STRB_WIDTH-1:0]   tcdm_req_be_o,
  output logic [shim_pkg::ID_WIDTH-1:0]     tcdm_req_id_o,
  input  logic                              tcdm_resp_valid_i,
  input  logic [shim_pkg::DATA_WIDTH-1:0]   tcdm_resp_rdata_i,
  input  logic [shim_pkg::ID_WIDTH-1:0]     tcdm_resp_id_i,
  // SoC port
  output logic                              soc_qvalid_o,
  input  logic                              soc_qready_i,
  output logic [shim_pkg::ADDR_WIDTH-1:0]   soc_qaddr_o,
  output logic                              soc_qwrite_o,
  output logic [shim_pkg::DATA_WIDTH-1:0]   soc_qdata_o,
  output logic [shim_pkg::STRB_WIDTH-1:0]   soc_qstrb_o,
  input  logic                              soc_pvalid_i,
  output logic                              soc_pready_o,
  input  logic [shim_pkg::DATA_WIDTH-1:0]   soc_pdata_i,
  input  logic                              soc_perror_i
);

  shim_pkg::addr_view_t          addr;
  logic                          rob_full;
  logic                          read_issue;
  logic [shim_pkg::ID_WIDTH-1:0] alloc_id;
  logic [shim_pkg::ID_WIDTH-1:0] soc_id;

  assign addr = data_qaddr_i;

  addr_demux i_addr_demux (
    .data_qaddr_i  (data_qaddr_i),
    .data_qwrite_i (data_qwrite_i),
    .data_qvalid_i (data_qvalid_i),
    .rob_full_i    (rob_full),
    .tcdm_ready_i  (tcdm_req_ready_i),
    .soc_ready_i   (soc_qready_i),
    .data_qready_o (data_qready_o),
    .tcdm_valid_o  (tcdm_req_valid_o),
    .soc_valid_o   (soc_qvalid_o),
    .read_issue_o  (read_issue)
  );

  // TCDM reads carry their id with the request
  assign tcdm_req_bank_o  = addr.tcdm.bank;
  assign tcdm_req_row_o   = addr.tcdm.row;
  assign tcdm_req_wen_o   = data_qwrite_i;
  assign tcdm_req_wdata_o = data_qdata_i;
  assign tcdm_req_be_o    = data_qstrb_i;
  assign tcdm_req_id_o    = alloc_id;

  assign soc_qaddr_o  = addr.soc;
  assign soc_qwrite_o = data_qwrite_i;
  assign soc_qdata_o  = data_qdata_i;
  assign soc_qstrb_o  = data_qstrb_i;

  soc_id_queue i_soc_id_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (read_issue & soc_qvalid_o),
    .id_i         (alloc_id),
    .soc_pvalid_i (soc_pvalid_i),
    .soc_pready_o (soc_pready_o),
    .id_o         (soc_id)
  );

  reorder_buffer i_reorder_buffer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alloc_i     (read_issue),
    .tcdm_push_i (tcdm_resp_valid_i),
    .tcdm_id_i   (tcdm_resp_id_i),
    .tcdm_data_i (tcdm_resp_rdata_i),
    .soc_push_i  (soc_pvalid_i & soc_pready_o),
    .soc_id_i    (soc_id),
    .soc_data_i  (soc_pdata_i),
    .soc_error_i (soc_perror_i),
    .pop_i       (data_pready_i),
    .alloc_id_o  (alloc_id),
    .full_o      (rob_full),
    .valid_o     (data_pvalid_o),
    .data_o      (data_pdata_o),
    .error_o     (data_perror_o)
  );

endmodule

// ==== reorder_buffer.sv ====
/*
 * Reorder buffer that hands out read ids in issue order, collects TCDM and SoC
 * responses by id and releases them in order, falling through at the head
 */
module reorder_buffer (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            alloc_i,
  input  logic                            tcdm_push_i,
  input  logic [shim_pkg::ID_WIDTH-1:0]   tcdm_id_i,
  input  logic [shim_pkg::DATA_WIDTH-1:0] tcdm_data_i,
  input  logic                            soc_push_i,
  input  logic [shim_pkg::ID_WIDTH-1:0]   soc_id_i,
  input  logic [shim_pkg::DATA_WIDTH-1:0] soc_data_i,
  input  logic                            soc_error_i,
  input  logic                            pop_i,
  output logic [shim_pkg::ID_WIDTH-1:0]   alloc_id_o,
  output logic                            full_o,
  output logic                            valid_o,
  output logic [shim_pkg::DATA_WIDTH-1:0] data_o,
  output logic                            error_o
);

  logic [shim_pkg::DATA_WIDTH-1:0]      data_q [shim_pkg::MAX_OUTSTANDING];
  logic [shim_pkg::MAX_OUTSTANDING-1:0] error_q;
  logic [shim_pkg::MAX_OUTSTANDING-1:0] filled_q;
  logic [shim_pkg::ID_WIDTH-1:0]        wr_ptr_q;
  logic [shim_pkg::ID_WIDTH-1:0]        rd_ptr_q;
  logic [shim_pkg::ID_WIDTH:0]          count_q;
  logic                                 head_tcdm_hit;
  logic                                 head_soc_hit;
  logic                                 pop;

  assign alloc_id_o = wr_ptr_q;
  assign full_o = count_q == (shim_pkg::ID_WIDTH + 1)'(shim_pkg::MAX_OUTSTANDING);

  // Response for the oldest id arriving right now
  assign head_tcdm_hit = tcdm_push_i & (tcdm_id_i == rd_ptr_q);
  assign head_soc_hit  = soc_push_i & (soc_id_i == rd_ptr_q);

  assign valid_o = filled_q[rd_ptr_q] | head_tcdm_hit | head_soc_hit;
  assign pop     = valid_o & pop_i;

  always_comb begin
    if (filled_q[rd_ptr_q]) begin
      data_o  = data_q[rd_ptr_q];
      error_o = error_q[rd_ptr_q];
    end else if (head_tcdm_hit) begin
      data_o  = tcdm_data_i;
      error_o = 1'b0;
    end else begin
      data_o  = soc_data_i;
      error_o = soc_error_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      filled_q <= '0;
    end else begin
      if (alloc_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (alloc_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!alloc_i && pop) begin
        count_q <= count_q - 1'b1;
      end
      if (tcdm_push_i) begin
        filled_q[tcdm_id_i] <= 1'b1;
      end
      if (soc_push_i) begin
        filled_q[soc_id_i] <= 1'b1;
      end
      // Clearing wins, so a fall-through response never lingers
      if (pop) begin
        filled_q[rd_ptr_q] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tcdm_push_i) begin
      data_q[tcdm_id_i]  <= tcdm_data_i;
      error_q[tcdm_id_i] <= 1'b0;
    end
    if (soc_push_i) begin
      data_q[soc_id_i]  <= soc_data_i;
      error_q[soc_id_i] <= soc_error_i;
    end
  end

endmodule

// ==== soc_id_queue.sv ====
/*
 * SoC id queue that keeps the reorder ids of accepted SoC reads so the
 * in-order SoC responses can be tagged for the reorder buffer
 */
module soc_id_queue (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          push_i,
  input  logic [shim_pkg::ID_WIDTH-1:0] id_i,
  input  logic                          soc_pvalid_i,
  output logic                          soc_pready_o,
  output logic [shim_pkg::ID_WIDTH-1:0] id_o
);

  logic [shim_pkg::ID_WIDTH-1:0] id_mem_q [shim_pkg::MAX_OUTSTANDING];
  logic [shim_pkg::ID_WIDTH-1:0] wr_ptr_q;
  logic [shim_pkg::ID_WIDTH-1:0] rd_ptr_q;
  logic                          pop;

  // Slot already reserved in the reorder buffer
  assign soc_pready_o = 1'b1;

  assign pop  = soc_pvalid_i & soc_pready_o;
  assign id_o = id_mem_q[rd_ptr_q];

  // Depth equals the reorder depth, so the queue cannot overflow
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_mem_q[wr_ptr_q] <= id_i;
    end
  end

endmodule

// ==== addr_demux.sv ====
/*
 * Address demux that steers a core request to the TCDM or the SoC port
 * and holds back reads while the reorder buffer has no free slot
 */
module addr_demux (
  input  logic [shim_pkg::ADDR_WIDTH-1:0] data_qaddr_i,
  input  logic                            data_qwrite_i,
  input  logic                            data_qvalid_i,
  input  logic                            rob_full_i,
  input  logic                            tcdm_ready_i,
  input  logic                            soc_ready_i,
  output logic                            data_qready_o,
  output logic                            tcdm_valid_o,
  output logic                            soc_valid_o,
  output logic                            read_issue_o
);

  shim_pkg::addr_view_t addr;
  logic to_tcdm;
  logic slot_ok;
  logic target_ready;

  assign addr = data_qaddr_i;

  // Only the region bits take part in the decode
  assign to_tcdm =
    (addr.tcdm.region & shim_pkg::TCDM_MASK[shim_pkg::ADDR_WIDTH-1 -: shim_pkg::REGION_WIDTH])
    == shim_pkg::TCDM_BASE[shim_pkg::ADDR_WIDTH-1 -: shim_pkg::REGION_WIDTH];

  // Writes are posted and need no reorder slot
  assign slot_ok = data_qwrite_i | ~rob_full_i;

  assign tcdm_valid_o = data_qvalid_i & slot_ok & to_tcdm;
  assign soc_valid_o  = data_qvalid_i & slot_ok & ~to_tcdm;

  always_comb begin
    if (to_tcdm) begin
      target_ready = tcdm_ready_i;
    end else begin
      target_ready = soc_ready_i;
    end
  end

  assign data_qready_o = target_ready & slot_ok;

  // One pulse per accepted read for id allocation
  assign read_issue_o = data_qvalid_i & data_qready_o & ~data_qwrite_i;

endmodule

// ==== shim_pkg.sv ====
/*
 * Data-port shim definitions with bus widths, reorder depth, the fixed
 * address map and the two decodings of a 32-bit address
 */
package shim_pkg;

  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned DATA_WIDTH      = 32;
  localparam int unsigned STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int unsigned MAX_OUTSTANDING = 8;
  localparam int unsigned ID_WIDTH        = $clog2(MAX_OUTSTANDING);

  localparam int unsigned REGION_WIDTH = 12;
  localparam int unsigned ROW_WIDTH    = 16;
  localparam int unsigned BANK_WIDTH   = 2;

  // Fixed address map
  localparam logic [ADDR_WIDTH-1:0] TCDM_BASE    = 32'h0010_0000;
  localparam logic [ADDR_WIDTH-1:0] TCDM_MASK    = 32'hfff0_0000;
  localparam logic [ADDR_WIDTH-1:0] SOC_ERR_BASE = 32'h4000_0000;
  localparam logic [ADDR_WIDTH-1:0] SOC_ERR_MASK = 32'hfff0_0000;

  typedef struct packed {
    logic [REGION_WIDTH-1:0] region;
    logic [ROW_WIDTH-1:0]    row;
    logic [BANK_WIDTH-1:0]   bank;
    logic [1:0]              offset;
  } tcdm_addr_t;

  typedef struct packed {
    logic [REGION_WIDTH-1:0]            region;
    logic [ADDR_WIDTH-REGION_WIDTH-1:0] offset;
  } soc_addr_t;

  typedef union packed {
    tcdm_addr_t tcdm;
    soc_addr_t  soc;
  } addr_view_t;

endpackage
